/* logic/go_pkg.sv */
`default_nettype none

package go_pkg;

    localparam int board_size = 9;

    // One-hot position along one axis, zero means off the board.
    typedef logic [board_size-1:0] coord_t;

    // Nine rows, indexed by y.
    typedef coord_t [board_size-1:0] plane_t;

    localparam coord_t center_coord = coord_t'(1 << 4);

    // 0: x down, 1: x up, 2: y down, 3: y up.
    typedef logic [1:0] dir_t;

    typedef enum logic [1:0] {
        idle     = 2'd0,
        neighbor = 2'd1,
        lib_step = 2'd2,
        decide   = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/button_edge.sv */
`timescale 1ns/1ps
`default_nettype none

module button_edge #(
    parameter int width = 4
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [width-1:0] level,
    output logic      [width-1:0] pulse
);

    logic [width-1:0] level_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_d <= '0;
        end else begin
            level_d <= level;
        end
    end

    // Rising edge, same cycle as the new level.
    assign pulse = level & ~level_d;

endmodule

`default_nettype wire

/* logic/cursor_mover.sv */
`timescale 1ns/1ps
`default_nettype none

module cursor_mover (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          move_left,
    input  wire logic          move_right,
    input  wire logic          move_up,
    input  wire logic          move_down,
    output go_pkg::coord_t     cursor_x,
    output go_pkg::coord_t     cursor_y
);

    go_pkg::coord_t left_x;
    go_pkg::coord_t right_x;
    go_pkg::coord_t up_y;
    go_pkg::coord_t down_y;

    // Shifted positions, zero when the step would leave the board.
    assign left_x  = cursor_x >> 1;
    assign right_x = cursor_x << 1;
    assign up_y    = cursor_y >> 1;
    assign down_y  = cursor_y << 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cursor_x <= go_pkg::center_coord;
            cursor_y <= go_pkg::center_coord;
        end else begin
            // Fixed priority: left, right, up, down.
            if (move_left) begin
                if (|left_x) begin
                    cursor_x <= left_x;
                end
            end else if (move_right) begin
                if (|right_x) begin
                    cursor_x <= right_x;
                end
            end else if (move_up) begin
                if (|up_y) begin
                    cursor_y <= up_y;
                end
            end else if (move_down) begin
                if (|down_y) begin
                    cursor_y <= down_y;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/board_planes.sv */
`timescale 1ns/1ps
`default_nettype none

module board_planes (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire go_pkg::coord_t qx,
    input  wire go_pkg::coord_t qy,
    output logic                q_black,
    output logic                q_white,
    input  wire logic           wr_en,
    input  wire logic           wr_set,
    input  wire logic           wr_white,
    input  wire go_pkg::coord_t wr_x,
    input  wire go_pkg::coord_t wr_y,
    output go_pkg::plane_t      black_plane,
    output go_pkg::plane_t      white_plane
);

    go_pkg::coord_t sel_black;
    go_pkg::coord_t sel_white;

    // Set or clear the write column in one row.
    function automatic go_pkg::coord_t apply_write(input go_pkg::coord_t row);
        if (wr_set) begin
            return row | wr_x;
        end
        return row & ~wr_x;
    endfunction

    // Row picked by qy, then masked by qx.
    always_comb begin
        sel_black = '0;
        sel_white = '0;
        for (int i = 0; i < go_pkg::board_size; i++) begin
            if (qy[i]) begin
                sel_black = sel_black | black_plane[i];
                sel_white = sel_white | white_plane[i];
            end
        end
    end

    assign q_black = |(sel_black & qx);
    assign q_white = |(sel_white & qx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            black_plane <= '0;
            white_plane <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < go_pkg::board_size; i++) begin
                if (wr_y[i]) begin
                    if (wr_white) begin
                        white_plane[i] <= apply_write(white_plane[i]);
                    end else begin
                        black_plane[i] <= apply_write(black_plane[i]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/move_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire go_pkg::coord_t cursor_x,
    input  wire go_pkg::coord_t cursor_y,
    input  wire logic           place_pulse,
    input  wire logic           pass_pulse,
    input  wire logic           q_black,
    input  wire logic           q_white,
    output go_pkg::coord_t      qx,
    output go_pkg::coord_t      qy,
    output logic                wr_en,
    output logic                wr_set,
    output logic                wr_white,
    output go_pkg::coord_t      wr_x,
    output go_pkg::coord_t      wr_y,
    output logic                busy,
    output logic                turn_white,
    output logic                cursor_free
);

    go_pkg::seq_state_t state;
    go_pkg::dir_t       dir;
    go_pkg::dir_t       sub_dir;
    go_pkg::coord_t     placed_x;
    go_pkg::coord_t     placed_y;
    go_pkg::coord_t     stone_x;
    go_pkg::coord_t     stone_y;
    go_pkg::coord_t     nx;
    go_pkg::coord_t     ny;
    go_pkg::coord_t     ax;
    go_pkg::coord_t     ay;
    logic               self_check;
    logic               has_lib;
    logic               captured;
    logic               n_valid;
    logic               a_valid;
    logic               q_occ;
    logic               opp_hit;
    logic               do_pass;
    logic               do_place;
    logic               do_capture;
    logic               do_undo;

    // One step in direction d; a step off the board zeroes that axis.
    function automatic logic [2*go_pkg::board_size-1:0] step_point(
        input go_pkg::coord_t x,
        input go_pkg::coord_t y,
        input go_pkg::dir_t   d
    );
        go_pkg::coord_t sx;
        go_pkg::coord_t sy;
        sx = x;
        sy = y;
        case (d)
            2'd0:    sx = x >> 1;
            2'd1:    sx = x << 1;
            2'd2:    sy = y >> 1;
            default: sy = y << 1;
        endcase
        return {sx, sy};
    endfunction

    assign {nx, ny} = step_point(placed_x, placed_y, dir);
    assign {ax, ay} = step_point(stone_x, stone_y, sub_dir);
    assign n_valid  = (|nx) & (|ny);
    assign a_valid  = (|ax) & (|ay);

    always_comb begin
        case (state)
            go_pkg::idle: begin
                qx = cursor_x;
                qy = cursor_y;
            end
            go_pkg::neighbor: begin
                qx = nx;
                qy = ny;
            end
            go_pkg::lib_step: begin
                qx = ax;
                qy = ay;
            end
            default: begin
                qx = '0;
                qy = '0;
            end
        endcase
    end

    assign q_occ   = q_black | q_white;
    assign opp_hit = n_valid & (turn_white ? q_black : q_white);

    assign do_pass    = (state == go_pkg::idle) & pass_pulse;
    assign do_place   = (state == go_pkg::idle) & place_pulse & ~pass_pulse & ~q_occ;
    assign do_capture = (state == go_pkg::decide) & ~self_check & ~has_lib;
    assign do_undo    = (state == go_pkg::decide) & self_check & ~has_lib & ~captured;

    // Single write port, at most one source per cycle.
    always_comb begin
        wr_en    = 1'b0;
        wr_set   = 1'b0;
        wr_white = turn_white;
        wr_x     = cursor_x;
        wr_y     = cursor_y;
        if (do_place) begin
            wr_en  = 1'b1;
            wr_set = 1'b1;
        end else if (do_capture) begin
            wr_en    = 1'b1;
            wr_white = ~turn_white;
            wr_x     = stone_x;
            wr_y     = stone_y;
        end else if (do_undo) begin
            wr_en = 1'b1;
            wr_x  = placed_x;
            wr_y  = placed_y;
        end
    end

    always_ff @(posedge clk) begin
        if (do_place) begin
            placed_x <= cursor_x;
            placed_y <= cursor_y;
        end
        if (state == go_pkg::neighbor) begin
            if (self_check) begin
                stone_x <= placed_x;
                stone_y <= placed_y;
            end else if (opp_hit) begin
                stone_x <= nx;
                stone_y <= ny;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= go_pkg::idle;
            turn_white <= 1'b0;
            dir        <= '0;
            sub_dir    <= '0;
            self_check <= 1'b0;
            has_lib    <= 1'b0;
            captured   <= 1'b0;
        end else begin
            case (state)
                go_pkg::idle: begin
                    if (do_pass) begin
                        turn_white <= ~turn_white;
                    end else if (do_place) begin
                        dir        <= '0;
                        self_check <= 1'b0;
                        captured   <= 1'b0;
                        state      <= go_pkg::neighbor;
                    end
                end
                go_pkg::neighbor: begin
                    if (self_check || opp_hit) begin
                        sub_dir <= '0;
                        has_lib <= 1'b0;
                        state   <= go_pkg::lib_step;
                    end else if (dir == 2'd3) begin
                        self_check <= 1'b1;
                    end else begin
                        dir <= dir + 2'd1;
                    end
                end
                go_pkg::lib_step: begin
                    // Single stones only, so any empty adjacent point is a liberty.
                    if (a_valid && !q_occ) begin
                        has_lib <= 1'b1;
                    end
                    sub_dir <= sub_dir + 2'd1;
                    if (sub_dir == 2'd3) begin
                        state <= go_pkg::decide;
                    end
                end
                default: begin
                    if (self_check) begin
                        // Suicide without capture keeps the turn.
                        if (has_lib || captured) begin
                            turn_white <= ~turn_white;
                        end
                        state <= go_pkg::idle;
                    end else begin
                        if (!has_lib) begin
                            captured <= 1'b1;
                        end
                        if (dir == 2'd3) begin
                            self_check <= 1'b1;
                        end else begin
                            dir <= dir + 2'd1;
                        end
                        state <= go_pkg::neighbor;
                    end
                end
            endcase
        end
    end

    assign busy        = (state != go_pkg::idle);
    assign cursor_free = (state == go_pkg::idle) & ~q_occ;

endmodule

`default_nettype wire

/* logic/row_display.sv */
`timescale 1ns/1ps
`default_nettype none

module row_display (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire go_pkg::plane_t black_plane,
    input  wire go_pkg::plane_t white_plane,
    input  wire go_pkg::coord_t cursor_x,
    input  wire go_pkg::coord_t cursor_y,
    input  wire logic           cursor_free,
    input  wire logic           turn_white,
    output logic                black,
    output logic                white,
    output go_pkg::plane_t      rows
);

    logic phase;
    logic show_cursor;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
        end
    end

    assign black = ~phase;
    assign white = phase;

    // Cursor only in the phase of the side to move.
    assign show_cursor = cursor_free & (phase == turn_white);

    always_comb begin
        for (int i = 0; i < go_pkg::board_size; i++) begin
            rows[i] = (phase ? white_plane[i] : black_plane[i])
                    | (cursor_x & {go_pkg::board_size{cursor_y[i] & show_cursor}});
        end
    end

endmodule

`default_nettype wire

/* logic/go_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module go_board_top (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           up,
    input  wire logic           down,
    input  wire logic           left,
    input  wire logic           right,
    input  wire logic           place,
    input  wire logic           pass,
    output wire logic           black,
    output wire logic           white,
    output wire logic           busy,
    output wire logic           turn_white,
    output wire go_pkg::plane_t rows
);

    logic [3:0]     dir_pulse;
    logic [1:0]     act_pulse;
    go_pkg::coord_t cursor_x;
    go_pkg::coord_t cursor_y;
    go_pkg::coord_t qx;
    go_pkg::coord_t qy;
    go_pkg::coord_t wr_x;
    go_pkg::coord_t wr_y;
    go_pkg::plane_t black_plane;
    go_pkg::plane_t white_plane;
    logic           q_black;
    logic           q_white;
    logic           wr_en;
    logic           wr_set;
    logic           wr_white;
    logic           cursor_free;

    // Bit order: left, right, up, down.
    button_edge #(.width(4)) dir_edge (
        .clk   (clk),
        .rst_n (rst_n),
        .level ({left, right, up, down}),
        .pulse (dir_pulse)
    );

    button_edge #(.width(2)) act_edge (
        .clk   (clk),
        .rst_n (rst_n),
        .level ({place, pass}),
        .pulse (act_pulse)
    );

    cursor_mover cursor (
        .clk        (clk),
        .rst_n      (rst_n),
        .move_left  (dir_pulse[3]),
        .move_right (dir_pulse[2]),
        .move_up    (dir_pulse[1]),
        .move_down  (dir_pulse[0]),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y)
    );

    move_sequencer sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .place_pulse (act_pulse[1]),
        .pass_pulse  (act_pulse[0]),
        .q_black     (q_black),
        .q_white     (q_white),
        .qx          (qx),
        .qy          (qy),
        .wr_en       (wr_en),
        .wr_set      (wr_set),
        .wr_white    (wr_white),
        .wr_x        (wr_x),
        .wr_y        (wr_y),
        .busy        (busy),
        .turn_white  (turn_white),
        .cursor_free (cursor_free)
    );

    board_planes planes (
        .clk         (clk),
        .rst_n       (rst_n),
        .qx          (qx),
        .qy          (qy),
        .q_black     (q_black),
        .q_white     (q_white),
        .wr_en       (wr_en),
        .wr_set      (wr_set),
        .wr_white    (wr_white),
        .wr_x        (wr_x),
        .wr_y        (wr_y),
        .black_plane (black_plane),
        .white_plane (white_plane)
    );

    row_display display (
        .clk         (clk),
        .rst_n       (rst_n),
        .black_plane (black_plane),
        .white_plane (white_plane),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .cursor_free (cursor_free),
        .turn_white  (turn_white),
        .black       (black),
        .white       (white),
        .rows        (rows)
    );

endmodule

`default_nettype wire

/* test/go_board_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module go_board_checker (
    input wire logic           clk,
    input wire logic           rst_n,
    input wire logic           wr_en,
    input wire logic           wr_set,
    input wire go_pkg::coord_t wr_x,
    input wire go_pkg::coord_t wr_y,
    input wire go_pkg::plane_t black_plane,
    input wire go_pkg::plane_t white_plane
);

    logic target_occ;
    int   fail_count = 0;

    // Stone already at the write point.
    always_comb begin
        target_occ = 1'b0;
        for (int i = 0; i < go_pkg::board_size; i++) begin
            if (wr_y[i]) begin
                target_occ = target_occ | (|((black_plane[i] | white_plane[i]) & wr_x));
            end
        end
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (black_plane & white_plane) == '0)
        else begin
            $error("a point is set in both planes");
            fail_count++;
        end

    set_on_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && wr_set) |-> !target_occ)
        else begin
            $error("a stone is written onto an occupied point");
            fail_count++;
        end

    onehot_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> ($onehot(wr_x) && $onehot(wr_y)))
        else begin
            $error("write coordinate is not one-hot");
            fail_count++;
        end

endmodule

bind board_planes go_board_checker plane_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_set      (wr_set),
    .wr_x        (wr_x),
    .wr_y        (wr_y),
    .black_plane (black_plane),
    .white_plane (white_plane)
);

`default_nettype wire

/* test/go_board_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module go_board_tb;

    typedef enum int {btn_left, btn_right, btn_up, btn_down, btn_place, btn_pass} button_t;

    logic           clk;
    logic           rst_n;
    logic           up;
    logic           down;
    logic           left;
    logic           right;
    logic           place;
    logic           pass;
    logic           black;
    logic           white;
    logic           busy;
    logic           turn_white;
    go_pkg::plane_t rows;

    // Reference board.
    go_pkg::plane_t m_black;
    go_pkg::plane_t m_white;
    int             cx;
    int             cy;
    logic           m_turn;
    int             dx [4] = '{-1, 1, 0, 0};
    int             dy [4] = '{0, 0, -1, 1};

    go_board_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .up         (up),
        .down       (down),
        .left       (left),
        .right      (right),
        .place      (place),
        .pass       (pass),
        .black      (black),
        .white      (white),
        .busy       (busy),
        .turn_white (turn_white),
        .rows       (rows)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (uut.planes.plane_checks.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [80:0] got,
                               input logic [80:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic on_board(input int x, input int y);
        return (x >= 0) && (x < go_pkg::board_size) && (y >= 0) && (y < go_pkg::board_size);
    endfunction

    function automatic logic occupied(input int x, input int y);
        return m_black[y][x] | m_white[y][x];
    endfunction

    function automatic logic has_liberty(input int x, input int y);
        logic lib;
        lib = 1'b0;
        for (int d = 0; d < 4; d++) begin
            if (on_board(x + dx[d], y + dy[d]) && !occupied(x + dx[d], y + dy[d])) begin
                lib = 1'b1;
            end
        end
        return lib;
    endfunction

    // Plane shown in a phase, with the cursor overlay for the side to move.
    function automatic go_pkg::plane_t expected_rows(input logic phase);
        go_pkg::plane_t r;
        r = phase ? m_white : m_black;
        if (!occupied(cx, cy) && (phase == m_turn)) begin
            r[cy][cx] = 1'b1;
        end
        return r;
    endfunction

    task automatic model_place();
        int   nx;
        int   ny;
        logic captured;
        captured = 1'b0;
        if (occupied(cx, cy)) begin
            return;
        end
        if (m_turn) begin
            m_white[cy][cx] = 1'b1;
        end else begin
            m_black[cy][cx] = 1'b1;
        end
        for (int d = 0; d < 4; d++) begin
            nx = cx + dx[d];
            ny = cy + dy[d];
            if (on_board(nx, ny) && (m_turn ? m_black[ny][nx] : m_white[ny][nx])
                    && !has_liberty(nx, ny)) begin
                m_black[ny][nx] = 1'b0;
                m_white[ny][nx] = 1'b0;
                captured = 1'b1;
            end
        end
        // Suicide is taken back and the turn stays.
        if (!has_liberty(cx, cy) && !captured) begin
            m_black[cy][cx] = 1'b0;
            m_white[cy][cx] = 1'b0;
        end else begin
            m_turn = !m_turn;
        end
    endtask

    task automatic press(input button_t b);
        @(negedge clk);
        case (b)
            btn_left:  left = 1'b1;
            btn_right: right = 1'b1;
            btn_up:    up = 1'b1;
            btn_down:  down = 1'b1;
            btn_place: place = 1'b1;
            default:   pass = 1'b1;
        endcase
        @(negedge clk);
        left  = 1'b0;
        right = 1'b0;
        up    = 1'b0;
        down  = 1'b0;
        place = 1'b0;
        pass  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles == 64) begin
                $display("Timeout: busy did not fall within 64 cycles");
                $display("Simulation failed");
                $fatal(1);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic step_cursor(input button_t b);
        press(b);
        case (b)
            btn_left:  cx = (cx > 0) ? cx - 1 : 0;
            btn_right: cx = (cx < 8) ? cx + 1 : 8;
            btn_up:    cy = (cy > 0) ? cy - 1 : 0;
            default:   cy = (cy < 8) ? cy + 1 : 8;
        endcase
    endtask

    task automatic move_to(input int tx, input int ty);
        while (cx > tx) step_cursor(btn_left);
        while (cx < tx) step_cursor(btn_right);
        while (cy > ty) step_cursor(btn_up);
        while (cy < ty) step_cursor(btn_down);
    endtask

    task automatic place_stone();
        logic starts;
        starts = !occupied(cx, cy);
        press(btn_place);
        check_value("busy", busy, starts);
        wait_idle();
        model_place();
    endtask

    task automatic pass_turn();
        press(btn_pass);
        wait_idle();
        m_turn = !m_turn;
    endtask

    // Samples both phases in consecutive cycles.
    task automatic check_board();
        logic first;
        @(negedge clk);
        first = white;
        check_value("black", black, !first);
        check_value("busy", busy, 1'b0);
        check_value("turn_white", turn_white, m_turn);
        check_value("rows", rows, expected_rows(first));
        @(negedge clk);
        check_value("white", white, !first);
        check_value("black", black, first);
        check_value("rows", rows, expected_rows(!first));
    endtask

    task automatic reset_state();
        check_value("black", black, 1'b1);
        check_value("white", white, 1'b0);
        check_value("turn_white", turn_white, 1'b0);
        check_board();
        check_board();
    endtask

    task automatic cursor_moves();
        repeat (6) begin
            step_cursor(btn_left);
            check_board();
        end
        repeat (6) begin
            step_cursor(btn_up);
            check_board();
        end
        check_value("cursor_x", uut.cursor_x, 9'h001);
        check_value("cursor_y", uut.cursor_y, 9'h001);
        repeat (10) begin
            step_cursor(btn_right);
            step_cursor(btn_down);
            check_board();
        end
        check_value("cursor_x", uut.cursor_x, 9'h100);
        check_value("cursor_y", uut.cursor_y, 9'h100);
    endtask

    task automatic placement();
        move_to(2, 2);
        place_stone();
        check_value("turn_white", turn_white, 1'b1);
        check_board();
        place_stone();
        check_value("turn_white", turn_white, 1'b1);
        check_board();
    endtask

    task automatic pass_moves();
        // Empty point, so the overlay is visible.
        step_cursor(btn_right);
        pass_turn();
        check_value("turn_white", turn_white, 1'b0);
        check_board();
        pass_turn();
        check_value("turn_white", turn_white, 1'b1);
        check_board();
    endtask

    task automatic capture();
        move_to(8, 0);
        place_stone();
        move_to(7, 0);
        place_stone();
        pass_turn();
        move_to(8, 1);
        place_stone();
        check_value("white stone at (8,0)", uut.white_plane[0][8], 1'b0);
        check_value("turn_white", turn_white, 1'b1);
        check_board();
    endtask

    task automatic suicide();
        move_to(8, 0);
        place_stone();
        check_value("white stone at (8,0)", uut.white_plane[0][8], 1'b0);
        check_value("turn_white", turn_white, 1'b1);
        check_board();
    endtask

    initial begin
        rst_n   = 1'b0;
        up      = 1'b0;
        down    = 1'b0;
        left    = 1'b0;
        right   = 1'b0;
        place   = 1'b0;
        pass    = 1'b0;
        m_black = '0;
        m_white = '0;
        cx      = 4;
        cy      = 4;
        m_turn  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        cursor_moves();
        placement();
        pass_moves();
        capture();
        suicide();
        if (uut.planes.plane_checks.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* project.f */
logic/go_pkg.sv
logic/button_edge.sv
logic/cursor_mover.sv
logic/board_planes.sv
logic/move_sequencer.sv
logic/row_display.sv
logic/go_board_top.sv
test/go_board_checker.sv
test/go_board_tb.sv
